//--- nn_defs.svh
`ifndef NN_DEFS_SVH
`define NN_DEFS_SVH

// ------------------------------
// word format, signed Q8.8
// ------------------------------
`define NN_DATA_W 16
`define NN_FRAC_W 8

// cell dimensions
`define NN_DIM 3
`define NN_VEC_W (`NN_DIM * `NN_DATA_W)

// ------------------------------
// frame schedule
// ------------------------------
// one matrix element of U, W, V and X per beat
`define NN_BEATS 9
// y_0..y_2, three words each
`define NN_OUT_WORDS 9

`endif

//--- source/nn_ctrl.sv
`timescale 1ns/1ps
`include "nn_defs.svh"

module nn_ctrl (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       in_valid,
	output logic       load_en,
	output logic [3:0] beat_idx,
	output logic [1:0] step,
	output logic       hidden_en,
	output logic       hidden_clr,
	output logic       out_en,
	output logic       drain_en,
	output logic [3:0] drain_idx
);

	import nn_pkg::*;

	nn_state_e  state;
	nn_state_e  state_nxt;
	// shared by load beats, compute steps and drain words
	logic [3:0] cnt;

	// ------------------------------
	// next state
	// ------------------------------
	always_comb
	begin
		state_nxt = state;
		case (state)
			IDLE:
				if (in_valid)
					state_nxt = LOAD;
			// one spare cycle after the ninth beat
			LOAD:
				if (cnt == `NN_BEATS)
					state_nxt = HIDDEN;
			HIDDEN:
				state_nxt = OUTPUT;
			OUTPUT:
				state_nxt = (cnt == `NN_DIM - 1) ? DRAIN : HIDDEN;
			DRAIN:
				if (cnt == `NN_OUT_WORDS - 1)
					state_nxt = IDLE;
			default:
				state_nxt = IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state <= IDLE;
			cnt <= '0;
		end
		else
		begin
			state <= state_nxt;
			case (state)
				// beat 0 is taken on the edge that leaves idle
				IDLE:
					cnt <= in_valid ? 4'd1 : 4'd0;
				LOAD:
					cnt <= (cnt == `NN_BEATS) ? 4'd0 : cnt + 4'd1;
				OUTPUT:
					cnt <= (cnt == `NN_DIM - 1) ? 4'd0 : cnt + 4'd1;
				DRAIN:
					cnt <= (cnt == `NN_OUT_WORDS - 1) ? 4'd0 : cnt + 4'd1;
				default:
					cnt <= cnt;
			endcase
		end
	end

	// ------------------------------
	// decoded controls
	// ------------------------------
	assign load_en    = in_valid && (state == IDLE || state == LOAD);
	assign beat_idx   = cnt;
	assign hidden_clr = in_valid && (state == IDLE);
	assign hidden_en  = (state == HIDDEN);
	assign out_en     = (state == OUTPUT);
	assign step       = cnt[1:0];
	assign drain_en   = (state == DRAIN);
	assign drain_idx  = cnt;

endmodule

//--- source/nn_hidden_cell.sv
`timescale 1ns/1ps
`include "nn_defs.svh"

module nn_hidden_cell (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            hidden_en,
	input  logic            hidden_clr,
	input  nn_pkg::nn_vec_t x_row,
	input  nn_pkg::nn_mat_t u_mat,
	input  nn_pkg::nn_mat_t w_mat,
	output nn_pkg::nn_vec_t h
);

	import nn_pkg::*;

	// ------------------------------
	// pre-activation
	// ------------------------------
	// U*x_t and W*h_{t-1} are added at full width, saturated once
	logic signed [31:0] acc [`NN_DIM];
	nn_word_t           z [`NN_DIM];
	nn_vec_t            u_row [`NN_DIM];
	nn_vec_t            w_row [`NN_DIM];
	nn_vec_t            h_nxt;

	always_comb
	begin
		h_nxt = '0;
		for (int i = 0; i < `NN_DIM; i++)
		begin
			u_row[i] = u_mat[i*`NN_VEC_W +: `NN_VEC_W];
			w_row[i] = w_mat[i*`NN_VEC_W +: `NN_VEC_W];
			acc[i] = nn_dot(u_row[i], x_row) + nn_dot(w_row[i], h);
			z[i] = nn_sat(acc[i]);
			h_nxt[i*`NN_DATA_W +: `NN_DATA_W] = nn_hsig(z[i]);
		end
	end

	// ------------------------------
	// hidden state
	// ------------------------------
	// clear gives h_{-1} = 0 for each new frame
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			h <= '0;
		else if (hidden_clr)
			h <= '0;
		else if (hidden_en)
			h <= h_nxt;
	end

endmodule

//--- source/nn_output_layer.sv
`timescale 1ns/1ps
`include "nn_defs.svh"

module nn_output_layer (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             out_en,
	input  logic [1:0]       step,
	input  logic             drain_en,
	input  logic [3:0]       drain_idx,
	input  nn_pkg::nn_mat_t  v_mat,
	input  nn_pkg::nn_vec_t  h,
	output logic             out_valid,
	output nn_pkg::nn_word_t out
);

	import nn_pkg::*;

	nn_vec_t v_row [`NN_DIM];
	nn_vec_t y;
	// y_t stored in row t
	nn_mat_t y_buf;
	int      rd_base;

	// ------------------------------
	// y_t = relu(V * h_t)
	// ------------------------------
	always_comb
	begin
		y = '0;
		for (int i = 0; i < `NN_DIM; i++)
		begin
			v_row[i] = v_mat[i*`NN_VEC_W +: `NN_VEC_W];
			y[i*`NN_DATA_W +: `NN_DATA_W] = nn_relu(nn_sat(nn_dot(v_row[i], h)));
		end
	end

	always_ff @(posedge clk)
	begin
		if (out_en)
		begin
			case (step)
				2'd0:    y_buf.r0 <= y;
				2'd1:    y_buf.r1 <= y;
				default: y_buf.r2 <= y;
			endcase
		end
	end

	// ------------------------------
	// serial output stage
	// ------------------------------
	// drain_idx walks the buffer in row-major order
	assign rd_base = int'(drain_idx) * `NN_DATA_W;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			out_valid <= 1'b0;
			out <= '0;
		end
		else
		begin
			out_valid <= drain_en;
			// zero between frames
			if (drain_en)
				out <= y_buf[rd_base +: `NN_DATA_W];
			else
				out <= '0;
		end
	end

endmodule

//--- source/nn_pkg.sv
`include "nn_defs.svh"

package nn_pkg;

	typedef logic signed [`NN_DATA_W-1:0] nn_word_t;

	// element 0 sits in the low bits
	typedef struct packed {
		nn_word_t e2;
		nn_word_t e1;
		nn_word_t e0;
	} nn_vec_t;

	// row 0 in the low bits, so element (r,c) is word r*3+c
	typedef struct packed {
		nn_vec_t r2;
		nn_vec_t r1;
		nn_vec_t r0;
	} nn_mat_t;

	typedef struct packed {
		nn_word_t u;
		nn_word_t w;
		nn_word_t v;
		nn_word_t x;
	} nn_beat_t;

	typedef enum logic [2:0] {
		IDLE,
		LOAD,
		HIDDEN,
		OUTPUT,
		DRAIN
	} nn_state_e;

	// ------------------------------
	// fixed point arithmetic
	// ------------------------------

	// three products, each rescaled back to Q8.8, summed at 32 bits
	function automatic logic signed [31:0] nn_dot(input nn_vec_t a, input nn_vec_t b);
		logic signed [31:0] p0;
		logic signed [31:0] p1;
		logic signed [31:0] p2;
		p0 = (a.e0 * b.e0) >>> `NN_FRAC_W;
		p1 = (a.e1 * b.e1) >>> `NN_FRAC_W;
		p2 = (a.e2 * b.e2) >>> `NN_FRAC_W;
		return p0 + p1 + p2;
	endfunction

	function automatic nn_word_t nn_sat(input logic signed [31:0] a);
		if (a > 32'sd32767)
			return 16'sh7fff;
		else if (a < -32'sd32768)
			return 16'sh8000;
		else
			return a[`NN_DATA_W-1:0];
	endfunction

	// z/4 + 0.5, clamped to [0, 1.0]
	function automatic nn_word_t nn_hsig(input nn_word_t z);
		logic signed [31:0] one;
		logic signed [31:0] t;
		one = 32'sd1 <<< `NN_FRAC_W;
		t = z;
		t = (t >>> 2) + (one >>> 1);
		if (t < 0)
			return '0;
		else if (t > one)
			return one[`NN_DATA_W-1:0];
		else
			return t[`NN_DATA_W-1:0];
	endfunction

	function automatic nn_word_t nn_relu(input nn_word_t a);
		return (a < 0) ? '0 : a;
	endfunction

endpackage

//--- source/nn_top.sv
`timescale 1ns/1ps

module nn_top (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             in_valid,
	input  nn_pkg::nn_beat_t beat,
	output logic             out_valid,
	output nn_pkg::nn_word_t out
);

	import nn_pkg::*;

	// ------------------------------
	// control
	// ------------------------------
	logic       load_en;
	logic [3:0] beat_idx;
	logic [1:0] step;
	logic       hidden_en;
	logic       hidden_clr;
	logic       out_en;
	logic       drain_en;
	logic [3:0] drain_idx;

	// datapath
	nn_mat_t u_mat;
	nn_mat_t w_mat;
	nn_mat_t v_mat;
	nn_vec_t x_row;
	nn_vec_t h;

	nn_ctrl u_ctrl (
		.clk        (clk),
		.rst_n      (rst_n),
		.in_valid   (in_valid),
		.load_en    (load_en),
		.beat_idx   (beat_idx),
		.step       (step),
		.hidden_en  (hidden_en),
		.hidden_clr (hidden_clr),
		.out_en     (out_en),
		.drain_en   (drain_en),
		.drain_idx  (drain_idx)
	);

	nn_weight_store u_store (
		.clk      (clk),
		.rst_n    (rst_n),
		.load_en  (load_en),
		.beat_idx (beat_idx),
		.step     (step),
		.beat     (beat),
		.u_mat    (u_mat),
		.w_mat    (w_mat),
		.v_mat    (v_mat),
		.x_row    (x_row)
	);

	nn_hidden_cell u_hidden (
		.clk        (clk),
		.rst_n      (rst_n),
		.hidden_en  (hidden_en),
		.hidden_clr (hidden_clr),
		.x_row      (x_row),
		.u_mat      (u_mat),
		.w_mat      (w_mat),
		.h          (h)
	);

	nn_output_layer u_out (
		.clk       (clk),
		.rst_n     (rst_n),
		.out_en    (out_en),
		.step      (step),
		.drain_en  (drain_en),
		.drain_idx (drain_idx),
		.v_mat     (v_mat),
		.h         (h),
		.out_valid (out_valid),
		.out       (out)
	);

endmodule

//--- source/nn_weight_store.sv
`timescale 1ns/1ps
`include "nn_defs.svh"

module nn_weight_store (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             load_en,
	input  logic [3:0]       beat_idx,
	input  logic [1:0]       step,
	input  nn_pkg::nn_beat_t beat,
	output nn_pkg::nn_mat_t  u_mat,
	output nn_pkg::nn_mat_t  w_mat,
	output nn_pkg::nn_mat_t  v_mat,
	output nn_pkg::nn_vec_t  x_row
);

	import nn_pkg::*;

	// time steps in rows, features in columns
	nn_mat_t x_mat;
	int      base;

	// bit offset of element beat_idx in row-major order
	assign base = int'(beat_idx) * `NN_DATA_W;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			u_mat <= '0;
			w_mat <= '0;
			v_mat <= '0;
			x_mat <= '0;
		end
		else if (load_en)
		begin
			u_mat[base +: `NN_DATA_W] <= beat.u;
			w_mat[base +: `NN_DATA_W] <= beat.w;
			v_mat[base +: `NN_DATA_W] <= beat.v;
			x_mat[base +: `NN_DATA_W] <= beat.x;
		end
	end

	// input vector x_t of the current step
	always_comb
	begin
		case (step)
			2'd0:    x_row = x_mat.r0;
			2'd1:    x_row = x_mat.r1;
			default: x_row = x_mat.r2;
		endcase
	end

endmodule

//--- tb.f
+incdir+.
source/nn_pkg.sv
source/nn_ctrl.sv
source/nn_weight_store.sv
source/nn_hidden_cell.sv
source/nn_output_layer.sv
source/nn_top.sv
test/tb_nn.sv

//--- test/nn_golden.txt
// per frame: nine input lines "u w v x" (element k of each matrix, row-major)
// then nine expected out words y_0[0..2] y_1[0..2] y_2[0..2], signed Q8.8
// frame 1: identity U and W, small positive V and X
0100 0100 0080 0040
0000 0000 0000 0080
0000 0000 0000 00c0
0000 0000 0040 0000
0100 0100 0040 0040
0000 0000 0000 0000
0000 0000 0000 0080
0000 0000 0080 0000
0100 0100 0100 0040
0048
004c
0100
0052
0057
0108
0064
005d
0112
// frame 2: large and negative weights
0400 0000 0200 0100
0000 0000 ff00 0080
0000 0080 0000 0080
fc00 0000 fd00 ff80
0000 0000 0180 0100
0000 0000 00c0 0000
0000 fe00 0000 0040
0200 0000 ff40 ff00
ff00 0000 0800 0200
0200
0000
0500
0000
01a4
0340
0160
0000
0000

//--- test/tb_nn.sv
`timescale 1ns/1ps
`include "nn_defs.svh"

module tb_nn;

	import nn_pkg::*;

	localparam int N_FRAMES = 2;
	// nine beats of four words, then the expected outputs
	localparam int FRAME_WORDS = `NN_BEATS * 4 + `NN_OUT_WORDS;
	localparam int CLK_HALF = 4;
	localparam int RST_CYCLES = 8;
	localparam int OUT_LAT = 8;
	localparam int MAX_GAP = 5;
	localparam int WAIT_LIMIT = 40;
	localparam int WDOG_CYCLES = N_FRAMES * 40 + 100;
	localparam logic [31:0] SEED = 32'hfadb_9a53;

	logic     clk;
	logic     rst_n;
	logic     in_valid;
	nn_beat_t beat;
	logic     out_valid;
	nn_word_t out;

	logic [`NN_DATA_W-1:0] golden [N_FRAMES * FRAME_WORDS];
	int errors;
	int checks;

	nn_top DUT (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.beat      (beat),
		.out_valid (out_valid),
		.out       (out)
	);

	always #(CLK_HALF) clk = ~clk;

	// ------------------------------
	// helpers
	// ------------------------------
	task automatic check_val(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		checks++;
		if (actual !== expected)
		begin
			errors++;
			$display("FAIL %s expected 0x%h actual 0x%h at %0t", name, expected, actual, $time);
		end
	endtask

	// beat k carries element k of U, W, V and X
	task automatic send_frame(input int f);
		int base;
		base = f * FRAME_WORDS;
		for (int k = 0; k < `NN_BEATS; k++)
		begin
			@(posedge clk);
			in_valid <= 1'b1;
			beat <= {golden[base + 4*k], golden[base + 4*k + 1],
				golden[base + 4*k + 2], golden[base + 4*k + 3]};
		end
		// this edge samples the ninth beat
		@(posedge clk);
		in_valid <= 1'b0;
		beat <= '0;
	endtask

	// latency counted from the edge that took the ninth beat
	task automatic check_frame(input int f);
		int base;
		int lat;
		base = f * FRAME_WORDS + `NN_BEATS * 4;
		lat = 0;
		@(negedge clk);
		while (out_valid !== 1'b1 && lat < WAIT_LIMIT)
		begin
			@(negedge clk);
			lat++;
		end
		if (out_valid !== 1'b1)
		begin
			errors++;
			$display("frame %0d gave no output within %0d cycles of its last beat",
				f, WAIT_LIMIT);
		end
		else
		begin
			check_val($sformatf("frame %0d out_valid latency", f), OUT_LAT, lat);
			for (int j = 0; j < `NN_OUT_WORDS; j++)
			begin
				if (j > 0)
				begin
					@(negedge clk);
					check_val($sformatf("frame %0d out_valid word %0d", f, j), 1, out_valid);
				end
				check_val($sformatf("frame %0d out word %0d", f, j), golden[base + j], out);
			end
			// exactly nine words per frame
			@(negedge clk);
			check_val($sformatf("frame %0d out_valid after last word", f), 0, out_valid);
		end
	endtask

	// ------------------------------
	// main sequence
	// ------------------------------
	initial
	begin
		int seed_ret;
		int gap;
		seed_ret = $urandom(SEED);
		errors = 0;
		checks = 0;
		clk = 1'b0;
		rst_n = 1'b0;
		in_valid = 1'b0;
		beat = '0;
		$readmemh("test/nn_golden.txt", golden);
		if ($isunknown(golden[N_FRAMES * FRAME_WORDS - 1]))
		begin
			errors++;
			$display("golden file test/nn_golden.txt is missing or too short");
		end
		repeat (RST_CYCLES) @(posedge clk);
		rst_n <= 1'b1;
		// quiet outputs before the first beat
		repeat (2)
		begin
			@(negedge clk);
			check_val("out_valid", 0, out_valid);
			check_val("out", 0, out);
		end
		for (int f = 0; f < N_FRAMES; f++)
		begin
			if (f > 0)
			begin
				gap = $urandom_range(MAX_GAP, 0);
				repeat (gap) @(posedge clk);
			end
			send_frame(f);
			check_frame(f);
		end
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

	// watchdog
	initial
	begin
		repeat (WDOG_CYCLES) @(posedge clk);
		$display("timeout, the run did not finish within %0d cycles", WDOG_CYCLES);
		$display("Checks failed");
		$finish;
	end

endmodule
